// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= vga_scope_tb
FILELIST  ?= scope.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Finished with no errors

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== scope.f ====
verilog/scope_pkg.sv
verilog/raster_position.sv
verilog/frame_minmax.sv
verilog/column_buffer.sv
verilog/trace_render.sv
verilog/vga_scope.sv
verif/vga_scope_tb.sv

// ==== verif/vga_scope_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module vga_scope_tb
	import scope_pkg::*;
();

	localparam int line_cycles = 900;
	localparam int frame_lines = 525;
	localparam int vsync_line  = 480;
	localparam int num_frames  = 5;
	// raster position to rgb
	localparam int latency     = 3;
	// six frames of raster plus margin for reset and drain
	localparam int max_cycles  = 6 * line_cycles * frame_lines + 1000;

	logic        clk;
	logic        reset;
	logic        blank;
	logic        vsync;
	logic        ad_strobe;
	sample_set_t samples;
	rgb_t        rgb;

	int   seed;
	int   errors;
	int   checks;
	int   cycles;
	logic narrow;
	int   centre [num_ch];

	// reference model state
	int                  m_x;
	int                  m_y;
	int                  m_wr_col;
	logic                m_blank_d;
	logic                m_vsync_d;
	logic                m_pulse;
	logic                m_vs_strobed;
	logic [sample_w-1:0] m_run_min [num_ch];
	logic [sample_w-1:0] m_run_max [num_ch];
	logic [sample_w-1:0] m_lat_min [num_ch];
	logic [sample_w-1:0] m_lat_max [num_ch];
	column_t             m_mem [int];
	// expected pixels still travelling through the DUT pipeline
	rgb_t                pipe_rgb [latency];
	logic                pipe_chk [latency];
	raster_pos_t         pipe_pos [latency];

	vga_scope vga_scope_i (
		.clk       (clk),
		.reset     (reset),
		.blank     (blank),
		.vsync     (vsync),
		.ad_strobe (ad_strobe),
		.samples   (samples),
		.rgb       (rgb)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > max_cycles) begin
			$display("timeout: no result after %0d clock cycles", cycles);
			$display("Finished with errors");
			$finish;
		end
	end

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	// narrow frames keep the bars short and wide ones make the bands overlap
	task automatic pick_frame_mode(int frame);
		int unsigned r;
		narrow = frame % 2 == 0;
		for (int k = 0; k < num_ch; k++) begin
			r = $random(seed);
			centre[k] = int'(r % 4000);
		end
	endtask

	function automatic logic [sample_w-1:0] draw_sample(int k);
		int unsigned r;
		r = $random(seed);
		if (narrow) begin
			return sample_w'(centre[k] + r % 64);
		end
		return sample_w'(r % 4096);
	endfunction

	task automatic drive_inputs(int line, int c);
		int unsigned r;
		blank = c >= screen_cols;
		vsync = line == vsync_line || line == vsync_line + 1;
		r = $random(seed);
		ad_strobe = r % 3 == 0;
		if (ad_strobe) begin
			samples.a0 = draw_sample(0);
			samples.a1 = draw_sample(1);
			samples.b0 = draw_sample(2);
			samples.b1 = draw_sample(3);
		end else begin
			// extreme levels would stretch every bar if not gated
			samples = {(num_ch * sample_w){r[3]}};
		end
	endtask

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	task automatic update_minmax();
		logic                boundary;
		logic [sample_w-1:0] s [num_ch];
		s[0] = samples.a0;
		s[1] = samples.a1;
		s[2] = samples.b0;
		s[3] = samples.b1;
		boundary = vsync && !m_vs_strobed;
		for (int k = 0; k < num_ch; k++) begin
			if (boundary) begin
				m_lat_min[k] = m_run_min[k];
				m_lat_max[k] = m_run_max[k];
				m_run_min[k] = s[k];
				m_run_max[k] = s[k];
			end else begin
				if (s[k] < m_run_min[k])
					m_run_min[k] = s[k];
				if (s[k] > m_run_max[k])
					m_run_max[k] = s[k];
			end
		end
		m_vs_strobed = vsync;
	endtask

	function automatic column_t latched_record();
		trace_minmax_t ch [num_ch];
		for (int k = 0; k < num_ch; k++) begin
			ch[k].min = trace_w'(m_lat_min[k] >> (sample_w - trace_w));
			ch[k].max = trace_w'(m_lat_max[k] >> (sample_w - trace_w));
		end
		return {ch[0], ch[1], ch[2], ch[3]};
	endfunction

	// bands in priority order, then the grid, otherwise black
	function automatic rgb_t expected_colour(int x, int y, column_t rec);
		trace_minmax_t ch [num_ch];
		rgb_t          band_colour [num_ch];
		int            rel;
		ch[0] = rec.a0;
		ch[1] = rec.a1;
		ch[2] = rec.b0;
		ch[3] = rec.b1;
		band_colour[0] = color_white;
		band_colour[1] = color_red;
		band_colour[2] = color_green;
		band_colour[3] = color_blue;
		for (int k = 0; k < num_ch; k++) begin
			rel = y - (trace_top + k * band_step);
			if (rel >= 0 && rel >= int'(ch[k].min) && rel <= int'(ch[k].max)) begin
				return band_colour[k];
			end
		end
		if (y >= trace_top && (x % 64 == grid_x_mask || y % 32 == grid_y_mask)) begin
			return color_grey;
		end
		return color_black;
	endfunction

	task automatic advance_model();
		int      col;
		column_t rec;
		for (int i = latency - 1; i > 0; i--) begin
			pipe_rgb[i] = pipe_rgb[i-1];
			pipe_chk[i] = pipe_chk[i-1];
			pipe_pos[i] = pipe_pos[i-1];
		end
		if (reset) begin
			m_x          = 0;
			m_y          = 0;
			m_wr_col     = screen_cols - 1;
			m_blank_d    = 1'b0;
			m_vsync_d    = 1'b0;
			m_pulse      = 1'b0;
			m_vs_strobed = 1'b0;
			for (int k = 0; k < num_ch; k++) begin
				m_run_min[k] = '0;
				m_run_max[k] = '0;
				m_lat_min[k] = '0;
				m_lat_max[k] = '0;
			end
			m_mem.delete();
			pipe_rgb[0] = color_black;
			pipe_chk[0] = 1'b1;
			pipe_pos[0] = '0;
		end else begin
			// write lands one edge after the pointer moved
			if (m_pulse) begin
				m_mem[m_wr_col] = latched_record();
			end
			m_pulse = m_vsync_d && !vsync;
			if (m_pulse) begin
				m_wr_col = (m_wr_col + 1) % (1 << col_aw);
			end
			m_vsync_d = vsync;
			if (ad_strobe) begin
				update_minmax();
			end
			m_x = blank ? 0 : (m_x + 1) % (1 << row_w);
			if (vsync) begin
				m_y = 0;
			end else if (blank && !m_blank_d) begin
				m_y = m_y + 1;
			end
			m_blank_d = blank;
			// newest column sits under the last visible x
			col = (m_wr_col - (screen_cols - 1) + m_x + (1 << col_aw)) % (1 << col_aw);
			rec = m_mem.exists(col) ? m_mem[col] : '0;
			pipe_rgb[0]   = expected_colour(m_x, m_y, rec);
			pipe_chk[0]   = (m_y < trace_top) || (m_mem.exists(col) != 0);
			pipe_pos[0].x = row_w'(m_x);
			pipe_pos[0].y = row_w'(m_y);
		end
	endtask

	task automatic check_output();
		if (pipe_chk[latency-1]) begin
			checks = checks + 1;
			if (rgb !== pipe_rgb[latency-1]) begin
				errors = errors + 1;
				$display("FAILED at %0t: rgb %06h, expected %06h at x %0d y %0d", $time, rgb,
					pipe_rgb[latency-1], pipe_pos[latency-1].x, pipe_pos[latency-1].y);
			end
		end
	endtask

	task run_cycle();
		@(negedge clk);
		check_output();
		advance_model();
	endtask

	initial begin
		clk       = 1'b0;
		reset     = 1'b1;
		blank     = 1'b0;
		vsync     = 1'b0;
		ad_strobe = 1'b0;
		samples   = '0;
		seed      = 46977;
		errors    = 0;
		checks    = 0;
		cycles    = 0;
		narrow    = 1'b0;
		for (int i = 0; i < latency; i++) begin
			pipe_rgb[i] = color_black;
			pipe_chk[i] = 1'b1;
			pipe_pos[i] = '0;
		end
		repeat (4) run_cycle();
		reset = 1'b0;
		for (int f = 0; f < num_frames; f++) begin
			for (int line = 0; line < frame_lines; line++) begin
				// min/max frames start at vsync
				if (line == vsync_line) begin
					pick_frame_mode(f);
				end
				for (int c = 0; c < line_cycles; c++) begin
					drive_inputs(line, c);
					run_cycle();
				end
			end
		end
		repeat (latency + 1) run_cycle();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/column_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module column_buffer
	import scope_pkg::*;
(
	input  wire logic              clk,
	input  wire logic              reset,
	input  wire logic              vsync,
	input  wire column_t           wr_data,
	input  wire logic [col_aw-1:0] rd_col,
	output logic      [col_aw-1:0] wr_col,
	output column_t                rd_data
);

	logic    vsync_d1;
	logic    vsync_fall;
	logic    wr_en;
	column_t mem [0:(1 << col_aw)-1];

	assign vsync_fall = vsync_d1 && !vsync;

	////////////////////////////////////////
	// write pulse and column pointer
	////////////////////////////////////////

	// pointer starts one short of screen_cols so the first frame
	// lands at column 800
	always_ff @(posedge clk) begin
		if (reset) begin
			vsync_d1 <= 1'b0;
			wr_en    <= 1'b0;
			wr_col   <= col_aw'(screen_cols - 1);
		end else begin
			vsync_d1 <= vsync;
			wr_en    <= vsync_fall;
			if (vsync_fall) begin
				// wraps at 1024
				wr_col <= wr_col + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// column storage
	////////////////////////////////////////

	// one write and one registered read per cycle
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_col] <= wr_data;
		end
		rd_data <= mem[rd_col];
	end

endmodule

`default_nettype wire

// ==== verilog/frame_minmax.sv ====
`timescale 1ns/10ps
`default_nettype none

module frame_minmax
	import scope_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic        vsync,
	input  wire logic        ad_strobe,
	input  wire sample_set_t samples,
	output column_t          latched
);

	logic                vsync_s;
	logic                boundary;
	logic [sample_w-1:0] smp     [num_ch];
	logic [sample_w-1:0] run_min [num_ch];
	logic [sample_w-1:0] run_max [num_ch];
	logic [sample_w-1:0] lat_min [num_ch];
	logic [sample_w-1:0] lat_max [num_ch];

	// channel index order a0, a1, b0, b1
	assign smp[0] = samples.a0;
	assign smp[1] = samples.a1;
	assign smp[2] = samples.b0;
	assign smp[3] = samples.b1;

	// vsync rising edge as seen by the strobe
	assign boundary = ad_strobe && vsync && !vsync_s;

	////////////////////////////////////////
	// running and latched min/max
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			vsync_s <= 1'b0;
			for (int k = 0; k < num_ch; k++) begin
				run_min[k] <= '0;
				run_max[k] <= '0;
				lat_min[k] <= '0;
				lat_max[k] <= '0;
			end
		end else if (ad_strobe) begin
			vsync_s <= vsync;
			for (int k = 0; k < num_ch; k++) begin
				if (boundary) begin
					// new frame starts from this sample while the old one is held
					run_min[k] <= smp[k];
					run_max[k] <= smp[k];
					lat_min[k] <= run_min[k];
					lat_max[k] <= run_max[k];
				end else begin
					if (smp[k] < run_min[k]) begin
						run_min[k] <= smp[k];
					end
					if (smp[k] > run_max[k]) begin
						run_max[k] <= smp[k];
					end
				end
			end
		end
	end

	// only the top bits go to the display
	assign latched.a0.min = lat_min[0][sample_w-1 -: trace_w];
	assign latched.a0.max = lat_max[0][sample_w-1 -: trace_w];
	assign latched.a1.min = lat_min[1][sample_w-1 -: trace_w];
	assign latched.a1.max = lat_max[1][sample_w-1 -: trace_w];
	assign latched.b0.min = lat_min[2][sample_w-1 -: trace_w];
	assign latched.b0.max = lat_max[2][sample_w-1 -: trace_w];
	assign latched.b1.min = lat_min[3][sample_w-1 -: trace_w];
	assign latched.b1.max = lat_max[3][sample_w-1 -: trace_w];

endmodule

`default_nettype wire

// ==== verilog/raster_position.sv ====
`timescale 1ns/10ps
`default_nettype none

module raster_position
	import scope_pkg::*;
(
	input  wire logic              clk,
	input  wire logic              reset,
	input  wire logic              blank,
	input  wire logic              vsync,
	input  wire logic [col_aw-1:0] wr_col,
	output raster_pos_t            pos,
	output logic      [col_aw-1:0] rd_col
);

	logic blank_d1;
	logic line_start;

	// first cycle of blank marks the end of a line
	assign line_start = blank && !blank_d1;

	////////////////////////////////////////
	// column and row counters
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			blank_d1 <= 1'b0;
			pos      <= '0;
		end else begin
			blank_d1 <= blank;

			if (blank) begin
				pos.x <= '0;
			end else begin
				pos.x <= pos.x + 1'b1;
			end

			if (vsync) begin
				pos.y <= '0;
			end else if (line_start) begin
				pos.y <= pos.y + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// scrolled read column
	////////////////////////////////////////

	// offset so that the newest column lands on the rightmost pixel
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_col <= '0;
		end else begin
			rd_col <= wr_col - col_aw'(screen_cols - 1) + col_aw'(pos.x);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/scope_pkg.sv ====
`default_nettype none

package scope_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	localparam int sample_w = 12;
	localparam int trace_w  = 8;
	localparam int num_ch   = 4;
	localparam int col_aw   = 10;
	localparam int row_w    = 10;

	////////////////////////////////////////
	// screen geometry
	////////////////////////////////////////

	// visible columns and how far back the scroll reaches
	localparam int screen_cols = 800;
	// scope area is the lower part of the 480 line screen
	localparam int trace_top   = 224;
	localparam int band_step   = 32;
	// grid lines where x low bits are all ones or y low bits are zero
	localparam int grid_x_mask = 63;
	localparam int grid_y_mask = 0;

	////////////////////////////////////////
	// colours
	////////////////////////////////////////

	localparam logic [23:0] color_white = 24'hffffff;
	localparam logic [23:0] color_red   = 24'hff0000;
	localparam logic [23:0] color_green = 24'h00ff00;
	localparam logic [23:0] color_blue  = 24'h0000ff;
	localparam logic [23:0] color_grey  = 24'h808080;
	localparam logic [23:0] color_black = 24'h000000;

	////////////////////////////////////////
	// shared types
	////////////////////////////////////////

	typedef struct packed {
		logic [sample_w-1:0] a0;
		logic [sample_w-1:0] a1;
		logic [sample_w-1:0] b0;
		logic [sample_w-1:0] b1;
	} sample_set_t;

	// one channel, already cut down to trace resolution
	typedef struct packed {
		logic [trace_w-1:0] min;
		logic [trace_w-1:0] max;
	} trace_minmax_t;

	// one buffer column
	typedef struct packed {
		trace_minmax_t a0;
		trace_minmax_t a1;
		trace_minmax_t b0;
		trace_minmax_t b1;
	} column_t;

	typedef struct packed {
		logic [row_w-1:0] x;
		logic [row_w-1:0] y;
	} raster_pos_t;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	// listed in colour priority order, highest first
	typedef enum logic [2:0] {
		src_a0,
		src_a1,
		src_b0,
		src_b1,
		src_grid,
		src_none
	} pixel_src_e;

endpackage

`default_nettype wire

// ==== verilog/trace_render.sv ====
`timescale 1ns/10ps
`default_nettype none

module trace_render
	import scope_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire raster_pos_t pos,
	input  wire column_t     rd_data,
	output rgb_t             rgb
);

	raster_pos_t   pos_d1;
	raster_pos_t   pos_d2;
	trace_minmax_t ch [num_ch];
	logic          [num_ch-1:0] hit;
	logic          in_scope;
	logic          grid_hit;
	pixel_src_e    src;

	////////////////////////////////////////
	// position delay
	////////////////////////////////////////

	// two cycles covers rd_col plus the buffer read
	always_ff @(posedge clk) begin
		if (reset) begin
			pos_d1 <= '0;
			pos_d2 <= '0;
		end else begin
			pos_d1 <= pos;
			pos_d2 <= pos_d1;
		end
	end

	assign ch[0] = rd_data.a0;
	assign ch[1] = rd_data.a1;
	assign ch[2] = rd_data.b0;
	assign ch[3] = rd_data.b1;

	////////////////////////////////////////
	// hit tests
	////////////////////////////////////////

	// each channel has its own band, starting band_step rows lower
	for (genvar k = 0; k < num_ch; k++) begin : g_band
		logic [row_w-1:0] band_base;
		logic [row_w-1:0] rel_y;

		assign band_base = row_w'(trace_top + k * band_step);
		assign rel_y     = pos_d2.y - band_base;
		assign hit[k]    = (pos_d2.y >= band_base)
			&& (rel_y >= row_w'(ch[k].min))
			&& (rel_y <= row_w'(ch[k].max));
	end

	assign in_scope = pos_d2.y >= row_w'(trace_top);

	// vertical line every 64 columns, horizontal every 32 rows
	assign grid_hit = in_scope
		&& ((pos_d2.x[5:0] == 6'(grid_x_mask)) || (pos_d2.y[4:0] == 5'(grid_y_mask)));

	////////////////////////////////////////
	// colour priority
	////////////////////////////////////////

	// nothing can hit above trace_top, so those rows fall through to black
	always_comb begin
		if (hit[0]) begin
			src = src_a0;
		end else if (hit[1]) begin
			src = src_a1;
		end else if (hit[2]) begin
			src = src_b0;
		end else if (hit[3]) begin
			src = src_b1;
		end else if (grid_hit) begin
			src = src_grid;
		end else begin
			src = src_none;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rgb <= color_black;
		end else begin
			case (src)
				src_a0:   rgb <= color_white;
				src_a1:   rgb <= color_red;
				src_b0:   rgb <= color_green;
				src_b1:   rgb <= color_blue;
				src_grid: rgb <= color_grey;
				default:  rgb <= color_black;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/vga_scope.sv ====
`timescale 1ns/10ps
`default_nettype none

module vga_scope
	import scope_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic        blank,
	input  wire logic        vsync,
	input  wire logic        ad_strobe,
	input  wire sample_set_t samples,
	output rgb_t             rgb
);

	raster_pos_t       pos;
	logic [col_aw-1:0] rd_col;
	logic [col_aw-1:0] wr_col;
	column_t           latched;
	column_t           rd_data;

	////////////////////////////////////////
	// raster decode
	////////////////////////////////////////

	raster_position raster_position_i (
		.clk    (clk),
		.reset  (reset),
		.blank  (blank),
		.vsync  (vsync),
		.wr_col (wr_col),
		.pos    (pos),
		.rd_col (rd_col)
	);

	////////////////////////////////////////
	// per-frame capture
	////////////////////////////////////////

	frame_minmax frame_minmax_i (
		.clk       (clk),
		.reset     (reset),
		.vsync     (vsync),
		.ad_strobe (ad_strobe),
		.samples   (samples),
		.latched   (latched)
	);

	// one column written per frame on vsync fall
	column_buffer column_buffer_i (
		.clk     (clk),
		.reset   (reset),
		.vsync   (vsync),
		.wr_data (latched),
		.rd_col  (rd_col),
		.wr_col  (wr_col),
		.rd_data (rd_data)
	);

	////////////////////////////////////////
	// pixel output
	////////////////////////////////////////

	trace_render trace_render_i (
		.clk     (clk),
		.reset   (reset),
		.pos     (pos),
		.rd_data (rd_data),
		.rgb     (rgb)
	);

endmodule

`default_nettype wire
